// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and register file sizing
`define WORD_W      32
`define REG_COUNT   32
`define REG_ADDR_W  5

// Primary opcodes, instr[31:26]
`define OP_RTYPE    6'h00
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b
`define OP_HALT     6'h3f

// R-type funct codes, instr[5:0]
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

// First fetch address
`define PC_INIT     32'h0000_0000

`endif

// ==== src/alu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu
  import cpuTypesPkg::*;
(
  input  wordT  a,
  input  wordT  b,
  input  aluOpT aluOp,
  output wordT  result,
  output logic  zero
);

  localparam int halfW = `WORD_W / 2;

  always_comb begin
    case (aluOp)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // Signed compare, result is 0 or 1
      ALU_SLT: result = wordT'($signed(a) < $signed(b));
      // Immediate into the upper half, low half cleared
      ALU_LUI: result = {b[halfW-1:0], {halfW{1'b0}}};
      default: result = '0;
    endcase
  end

  // Equal operands after a subtract
  assign zero = (result == '0);

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module controlUnit
  import cpuTypesPkg::*;
(
  input  wordT instr,
  output ctrlT ctrl
);

  opcodeT opcode;
  functT  funct;

  // Top six bits and bottom six bits of the instruction word
  assign opcode = opcodeT'(instr[`WORD_W-1 -: 6]);
  assign funct  = functT'(instr[5:0]);

  always_comb begin
    // Anything unrecognised falls out as a no-op
    ctrl = '0;
    case (opcode)
      RTYPE: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDstRd = 1'b1;
        case (funct)
          ADDU:    ctrl.aluOp = ALU_ADD;
          SUBU:    ctrl.aluOp = ALU_SUB;
          AND:     ctrl.aluOp = ALU_AND;
          OR:      ctrl.aluOp = ALU_OR;
          SLT:     ctrl.aluOp = ALU_SLT;
          default: ctrl = '0;
        endcase
      end
      ADDIU: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.extSigned = 1'b1;
        ctrl.aluOp     = ALU_ADD;
      end
      // Logical immediate is zero extended
      ORI: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = ALU_OR;
      end
      LUI: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = ALU_LUI;
      end
      // Base plus signed offset for both memory ops
      LW: begin
        ctrl.regWrite  = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.extSigned = 1'b1;
        ctrl.aluOp     = ALU_ADD;
      end
      SW: begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.extSigned = 1'b1;
        ctrl.aluOp     = ALU_ADD;
      end
      // Compare by subtract, offset sign extended for the target
      BEQ: begin
        ctrl.branchEq  = 1'b1;
        ctrl.extSigned = 1'b1;
        ctrl.aluOp     = ALU_SUB;
      end
      BNE: begin
        ctrl.branchNe  = 1'b1;
        ctrl.extSigned = 1'b1;
        ctrl.aluOp     = ALU_SUB;
      end
      HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

endmodule

// ==== src/cpuTypesPkg.sv ====
`include "cpu_defines.svh"

package cpuTypesPkg;

  typedef logic [`WORD_W-1:0]     wordT;
  typedef logic [`REG_ADDR_W-1:0] regAddrT;

  typedef enum logic [5:0] {
    RTYPE = `OP_RTYPE,
    BEQ   = `OP_BEQ,
    BNE   = `OP_BNE,
    ADDIU = `OP_ADDIU,
    ORI   = `OP_ORI,
    LUI   = `OP_LUI,
    LW    = `OP_LW,
    SW    = `OP_SW,
    HALT  = `OP_HALT
  } opcodeT;

  typedef enum logic [5:0] {
    ADDU = `FN_ADDU,
    SUBU = `FN_SUBU,
    AND  = `FN_AND,
    OR   = `FN_OR,
    SLT  = `FN_SLT
  } functT;

  // ALU_ADD is zero so an empty control word still decodes cleanly
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluOpT;

  // All zero means no-op
  typedef struct packed {
    logic  regWrite;
    logic  memToReg;
    logic  memRead;
    logic  memWrite;
    logic  aluSrcImm;
    logic  regDstRd;
    logic  extSigned;
    logic  branchEq;
    logic  branchNe;
    logic  halt;
    aluOpT aluOp;
  } ctrlT;

  //////////////////////////////
  // Stage latch payloads
  //////////////////////////////

  // IF/ID
  typedef struct packed {
    wordT instr;
    wordT pcPlus4;
  } fetchLatchT;

  // ID/EX
  typedef struct packed {
    ctrlT    ctrl;
    wordT    pcPlus4;
    wordT    busA;
    wordT    busB;
    wordT    imm;
    regAddrT rs;
    regAddrT rt;
    regAddrT dest;
  } decodeLatchT;

  // EX/MEM
  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    memRead;
    logic    memWrite;
    logic    halt;
    wordT    result;
    wordT    storeData;
    regAddrT dest;
  } execLatchT;

  // MEM/WB
  typedef struct packed {
    logic    regWrite;
    logic    memToReg;
    logic    halt;
    wordT    result;
    wordT    loadData;
    regAddrT dest;
  } memLatchT;

endpackage

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath
  import cpuTypesPkg::*;
(
  input  logic CLK,
  input  logic nRST,
  input  logic ihit,
  input  wordT imemload,
  output logic imemREN,
  output wordT imemaddr,
  input  logic dhit,
  input  wordT dmemload,
  output logic dmemREN,
  output logic dmemWEN,
  output wordT dmemaddr,
  output wordT dmemstore,
  output logic halt
);

  wordT        pc, pcNext, pcPlus4, branchTarget;
  logic        advance;
  fetchLatchT  fetchD, fetchQ;
  decodeLatchT decodeD, decodeQ;
  execLatchT   execD, execQ;
  memLatchT    memD, memQ;
  ctrlT        ctrl;
  regAddrT     decRs, decRt, decRd;
  wordT        busA, busB, extImm, wbData;
  wordT        opA, fwdRt, opB, storeData, aluResult;
  logic        zero, branchTaken, stall, flush;
  logic [1:0]  fwdA, fwdB, fwdStore;

  //////////////////////////////
  // Freeze and fetch
  //////////////////////////////

  // Move only with an instruction and any pending data access satisfied
  assign advance = ihit && !halt && (!(execQ.memRead || execQ.memWrite) || dhit);

  assign pcPlus4 = pc + 32'd4;
  assign pcNext  = branchTaken ? branchTarget : pcPlus4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= `PC_INIT;
    end else if (advance && !stall) begin
      pc <= pcNext;
    end
  end

  assign imemaddr = pc;
  assign imemREN  = !halt;
  assign fetchD   = '{instr: imemload, pcPlus4: pcPlus4};

  pipeRegister #(.payloadT(fetchLatchT)) fetchLatch (
    .CLK(CLK), .nRST(nRST), .enable(advance && !stall), .flush(flush),
    .d(fetchD), .q(fetchQ)
  );

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign decRs = fetchQ.instr[25:21];
  assign decRt = fetchQ.instr[20:16];
  assign decRd = fetchQ.instr[15:11];

  controlUnit ctrlUnit0 (.instr(fetchQ.instr), .ctrl(ctrl));

  registerFile regFile0 (
    .CLK(CLK), .nRST(nRST), .wen(memQ.regWrite && advance), .wsel(memQ.dest),
    .wdat(wbData), .rsel1(decRs), .rsel2(decRt), .rdat1(busA), .rdat2(busB)
  );

  // Sign or zero extend the 16-bit immediate
  assign extImm = ctrl.extSigned ? {{(`WORD_W-16){fetchQ.instr[15]}}, fetchQ.instr[15:0]}
                                 : {{(`WORD_W-16){1'b0}}, fetchQ.instr[15:0]};

  assign decodeD = '{ctrl: ctrl, pcPlus4: fetchQ.pcPlus4, busA: busA, busB: busB,
                     imm: extImm, rs: decRs, rt: decRt,
                     dest: ctrl.regDstRd ? decRd : decRt};

  // Stall drops a bubble into execute
  pipeRegister #(.payloadT(decodeLatchT)) decodeLatch (
    .CLK(CLK), .nRST(nRST), .enable(advance), .flush(stall || flush),
    .d(decodeD), .q(decodeQ)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  // Forward muxes
  always_comb begin
    case (fwdA)
      2'd1:    opA = execQ.result;
      2'd2:    opA = wbData;
      default: opA = decodeQ.busA;
    endcase
    case (fwdB)
      2'd1:    fwdRt = execQ.result;
      2'd2:    fwdRt = wbData;
      default: fwdRt = decodeQ.busB;
    endcase
    case (fwdStore)
      2'd1:    storeData = execQ.result;
      2'd2:    storeData = wbData;
      default: storeData = decodeQ.busB;
    endcase
  end

  assign opB = decodeQ.ctrl.aluSrcImm ? decodeQ.imm : fwdRt;

  alu alu0 (.a(opA), .b(opB), .aluOp(decodeQ.ctrl.aluOp), .result(aluResult), .zero(zero));

  // Word offset relative to the delay-free PC+4
  assign branchTarget = decodeQ.pcPlus4 + (decodeQ.imm << 2);
  assign branchTaken  = (decodeQ.ctrl.branchEq && zero) || (decodeQ.ctrl.branchNe && !zero);

  hazardUnit hazard0 (
    .decRs(decRs), .decRt(decRt), .exRs(decodeQ.rs), .exRt(decodeQ.rt),
    .exMemRead(decodeQ.ctrl.memRead), .memDest(execQ.dest), .memRegWrite(execQ.regWrite),
    .wbDest(memQ.dest), .wbRegWrite(memQ.regWrite), .branchTaken(branchTaken),
    .fwdA(fwdA), .fwdB(fwdB), .fwdStore(fwdStore), .stall(stall), .flush(flush)
  );

  assign execD = '{regWrite: decodeQ.ctrl.regWrite, memToReg: decodeQ.ctrl.memToReg,
                   memRead: decodeQ.ctrl.memRead, memWrite: decodeQ.ctrl.memWrite,
                   halt: decodeQ.ctrl.halt, result: aluResult, storeData: storeData,
                   dest: decodeQ.dest};

  pipeRegister #(.payloadT(execLatchT)) execLatch (
    .CLK(CLK), .nRST(nRST), .enable(advance), .flush(1'b0), .d(execD), .q(execQ)
  );

  //////////////////////////////
  // Memory and write-back
  //////////////////////////////

  // Request held from the latch until dhit
  assign dmemREN   = execQ.memRead;
  assign dmemWEN   = execQ.memWrite;
  assign dmemaddr  = execQ.result;
  assign dmemstore = execQ.storeData;

  assign memD = '{regWrite: execQ.regWrite, memToReg: execQ.memToReg, halt: execQ.halt,
                  result: execQ.result, loadData: dmemload, dest: execQ.dest};

  pipeRegister #(.payloadT(memLatchT)) memLatch (
    .CLK(CLK), .nRST(nRST), .enable(advance), .flush(1'b0), .d(memD), .q(memQ)
  );

  assign wbData = memQ.memToReg ? memQ.loadData : memQ.result;

  // HALT parked in the last latch
  assign halt = memQ.halt;

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit
  import cpuTypesPkg::*;
(
  input  regAddrT    decRs,
  input  regAddrT    decRt,
  input  regAddrT    exRs,
  input  regAddrT    exRt,
  input  logic       exMemRead,
  input  regAddrT    memDest,
  input  logic       memRegWrite,
  input  regAddrT    wbDest,
  input  logic       wbRegWrite,
  input  logic       branchTaken,
  output logic [1:0] fwdA,
  output logic [1:0] fwdB,
  output logic [1:0] fwdStore,
  output logic       stall,
  output logic       flush
);

  // Select 0 is the register, 1 the memory-stage result and 2 the write-back data
  function automatic logic [1:0] pickSource(regAddrT src, regAddrT mDst, logic mWr,
                                            regAddrT wDst, logic wWr);
    logic [1:0] sel;
    sel = 2'd0;
    // Younger producer wins and register 0 is never forwarded
    if (src != '0 && mWr && mDst == src) begin
      sel = 2'd1;
    end else if (src != '0 && wWr && wDst == src) begin
      sel = 2'd2;
    end
    return sel;
  endfunction

  logic [1:0] rtSource;

  assign fwdA     = pickSource(exRs, memDest, memRegWrite, wbDest, wbRegWrite);
  assign rtSource = pickSource(exRt, memDest, memRegWrite, wbDest, wbRegWrite);

  // rt feeds both the ALU operand and the store data
  assign fwdB     = rtSource;
  assign fwdStore = rtSource;

  // Load in execute whose rt matches a decode source
  assign stall = exMemRead && exRt != '0 && (exRt == decRs || exRt == decRt);
  assign flush = branchTaken;

endmodule

// ==== src/pipeRegister.sv ====
`timescale 1ns/1ps

module pipeRegister #(
  parameter type payloadT = logic [31:0]
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    enable,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // Zero payload is a bubble, every control field inactive
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= payloadT'('0);
    end else if (enable) begin
      // Flush only takes effect on an advancing edge
      q <= flush ? payloadT'('0) : d;
    end
  end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
  import cpuTypesPkg::*;
(
  input  logic    CLK,
  input  logic    nRST,
  input  logic    wen,
  input  regAddrT wsel,
  input  wordT    wdat,
  input  regAddrT rsel1,
  input  regAddrT rsel2,
  output wordT    rdat1,
  output wordT    rdat2
);

  localparam int depth = 2 ** $bits(regAddrT);

  // Register 0 has no storage
  wordT regs [1:depth-1];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // Write-through so decode sees the value being written back this cycle
  always_comb begin
    if (rsel1 == '0) begin
      rdat1 = '0;
    end else if (wen && wsel == rsel1) begin
      rdat1 = wdat;
    end else begin
      rdat1 = regs[rsel1];
    end
  end

  always_comb begin
    if (rsel2 == '0) begin
      rdat2 = '0;
    end else if (wen && wsel == rsel2) begin
      rdat2 = wdat;
    end else begin
      rdat2 = regs[rsel2];
    end
  end

endmodule

// ==== test/cpuChecker.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuChecker
  import cpuTypesPkg::*;
(
  input logic CLK,
  input logic nRST,
  input logic imemREN,
  input wordT imemaddr,
  input logic dmemREN,
  input logic dmemWEN,
  input wordT dmemaddr,
  input wordT dmemstore,
  input logic dhit,
  input logic halt
);

  // Expected write list filled by the ISA model
  wordT  expAddr [0:63];
  wordT  expData [0:63];
  int    expCount = 0;
  int    seenCount = 0;
  int    testErrors = 0;
  int    testsRun = 0;
  int    testsFailed = 0;
  logic  haltSeen = 1'b0;
  string testName = "";

  task automatic compareWord(input string sig, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("ERROR %s write %0d: expected %h, got %h", sig, seenCount, exp, got);
      testErrors++;
    end
  endtask

  task automatic compareBit(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s in reset: expected %h, got %h", sig, exp, got);
      testErrors++;
    end
  endtask

  task automatic startTest(input string name);
    testName   = name;
    expCount   = 0;
    seenCount  = 0;
    testErrors = 0;
  endtask

  task automatic addExpected(input wordT addr, input wordT data);
    expAddr[expCount] = addr;
    expData[expCount] = data;
    expCount++;
  endtask

  // Outputs while nRST is held low
  task automatic checkReset();
    compareBit("dmemWEN", dmemWEN, 1'b0);
    compareBit("dmemREN", dmemREN, 1'b0);
    compareBit("halt", halt, 1'b0);
    compareBit("imemREN", imemREN, 1'b1);
    // Fetch parked at the reset PC
    if (imemaddr !== `PC_INIT) begin
      $display("ERROR imemaddr in reset: expected %h, got %h", `PC_INIT, imemaddr);
      testErrors++;
    end
  endtask

  task automatic finishTest();
    if (seenCount < expCount) begin
      $display("Test %s is missing data writes, expected %0d but saw %0d",
               testName, expCount, seenCount);
      testErrors++;
    end
    if (!halt) begin
      $display("Test %s ended with halt low", testName);
      testErrors++;
    end
    testsRun++;
    if (testErrors != 0) begin
      testsFailed++;
    end
    $display("Test %0d %s: %s, %0d writes checked, %0d errors", testsRun, testName,
             (testErrors == 0) ? "PASS" : "FAIL", seenCount, testErrors);
  endtask

  task automatic reportTotals();
    $display("Tests run %0d, passed %0d, failed %0d", testsRun, testsRun - testsFailed,
             testsFailed);
  endtask

  //////////////////////////////
  // Write and halt monitor
  //////////////////////////////

  // Sampled mid-cycle where every DUT output has settled
  always @(negedge CLK) begin
    if (!nRST) begin
      haltSeen = 1'b0;
    end else begin
      if (dmemWEN && dhit) begin
        if (halt || haltSeen) begin
          $display("Data write to %h after halt in test %s", dmemaddr, testName);
          testErrors++;
        end else if (seenCount >= expCount) begin
          $display("Extra data write to %h beyond the %0d expected in test %s",
                   dmemaddr, expCount, testName);
          testErrors++;
        end else begin
          compareWord("dmemaddr", dmemaddr, expAddr[seenCount]);
          compareWord("dmemstore", dmemstore, expData[seenCount]);
        end
        seenCount++;
      end
      // Halt must stay up once raised
      if (halt) begin
        haltSeen = 1'b1;
      end else if (haltSeen) begin
        $display("Halt dropped after rising in test %s", testName);
        testErrors++;
        haltSeen = 1'b0;
      end
    end
  end

endmodule

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTb
  import cpuTypesPkg::*;
();

  localparam int numTests = 6;
  localparam int timeoutCycles = numTests * 40 * 8;
  // Seven seeding ADDIUs plus 24 random instructions
  localparam int bodyEnd = 31;
  localparam int kindAlu = 1;
  localparam int kindImm = 2;
  localparam int kindMem = 4;
  localparam int kindBr = 8;

  logic CLK, nRST, ihit, dhit, imemREN, dmemREN, dmemWEN, halt;
  wordT imemload, imemaddr, dmemload, dmemaddr, dmemstore;
  wordT imem [0:63];
  wordT dmem [0:63];
  logic waitMode, instrReady;
  int unsigned seedVal, dummy;
  int cycleCount = 0;

  tbClock #(.periodNs(20)) clk0 (.CLK(CLK));

  datapath dut0 (
    .CLK(CLK), .nRST(nRST), .ihit(ihit), .imemload(imemload), .imemREN(imemREN),
    .imemaddr(imemaddr), .dhit(dhit), .dmemload(dmemload), .dmemREN(dmemREN),
    .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt)
  );

  cpuChecker chk0 (
    .CLK(CLK), .nRST(nRST), .imemREN(imemREN), .imemaddr(imemaddr), .dmemREN(dmemREN),
    .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dhit(dhit),
    .halt(halt)
  );

  //////////////////////////////
  // Memories
  //////////////////////////////

  // Asynchronous read ports with registered hits
  assign imemload = imem[imemaddr[7:2]];
  assign dmemload = dmem[dmemaddr[7:2]];

  always @(posedge CLK) begin
    if (waitMode) begin
      instrReady = $urandom % 2;
      ihit <= instrReady;
      // Data hit only alongside an instruction hit
      dhit <= instrReady && ($urandom % 2 == 1);
    end else begin
      ihit <= 1'b1;
      dhit <= 1'b1;
    end
    if (dmemWEN && dhit) begin
      dmem[dmemaddr[7:2]] <= dmemstore;
    end
  end

  // Watchdog
  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      $display("Timeout after %0d cycles, halt was never reached", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Program generator
  //////////////////////////////

  function automatic wordT encodeR(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                   logic [4:0] rd);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic wordT encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                   logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // One of r1 to r7
  function automatic logic [4:0] pickReg();
    logic [4:0] r;
    r = $urandom % 7;
    return r + 5'd1;
  endfunction

  function automatic logic [5:0] pickFunct();
    logic [5:0] f;
    case ($urandom % 5)
      0: f = `FN_ADDU;
      1: f = `FN_SUBU;
      2: f = `FN_AND;
      3: f = `FN_OR;
      default: f = `FN_SLT;
    endcase
    return f;
  endfunction

  task automatic buildProgram(input int kinds);
    int n;
    int kind;
    int skip;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [15:0] imm;
    logic [5:0] op;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
    n = 0;
    // Nonzero starting registers
    for (int r = 1; r < 8; r++) begin
      ra = r;
      imm = $urandom;
      imem[n] = encodeI(`OP_ADDIU, 5'd0, ra, imm);
      n++;
    end
    while (n < bodyEnd) begin
      kind = $urandom % 4;
      if ((kinds >> kind) & 1) begin
        ra = pickReg();
        rb = pickReg();
        imm = $urandom;
        case (kind)
          0: imem[n] = encodeR(pickFunct(), ra, rb, pickReg());
          1: begin
            case ($urandom % 3)
              0: imem[n] = encodeI(`OP_ADDIU, ra, rb, imm);
              1: imem[n] = encodeI(`OP_ORI, ra, rb, imm);
              default: imem[n] = encodeI(`OP_LUI, 5'd0, rb, imm);
            endcase
          end
          2: begin
            imm = ($urandom % 16) * 4;
            if ($urandom % 2) begin
              imem[n] = encodeI(`OP_LW, 5'd0, ra, imm);
              // Consumer right behind the load
              if (n + 1 < bodyEnd) begin
                n++;
                imm = ($urandom % 16) * 4;
                imem[n] = ($urandom % 2) ? encodeR(`FN_ADDU, ra, rb, pickReg())
                                         : encodeI(`OP_SW, 5'd0, ra, imm);
              end
            end else begin
              imem[n] = encodeI(`OP_SW, 5'd0, ra, imm);
            end
          end
          default: begin
            // Equal operands half the time
            if ($urandom % 2) begin
              rb = ra;
            end
            skip = 1 + $urandom % 3;
            if (n + 1 + skip > bodyEnd) begin
              skip = bodyEnd - n - 1;
            end
            imm = skip;
            op = ($urandom % 2) ? `OP_BEQ : `OP_BNE;
            imem[n] = encodeI(op, ra, rb, imm);
          end
        endcase
        n++;
      end
    end
    // Dump r1 to r7 to addresses 64 to 88 and stop
    for (int r = 1; r < 8; r++) begin
      ra = r;
      imm = 60 + 4 * r;
      imem[n] = encodeI(`OP_SW, 5'd0, ra, imm);
      n++;
    end
    imem[n] = {`OP_HALT, 26'd0};
  endtask

  //////////////////////////////
  // ISA model
  //////////////////////////////

  // Sequential execution that hands every store to the checker in order
  task automatic runModel();
    wordT regs [0:31];
    wordT refMem [0:63];
    wordT ins, a, b, sImm, zImm, addr;
    int pcIdx;
    int steps;
    logic done;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      refMem[i] = dmem[i];
    end
    pcIdx = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 64) begin
      ins = imem[pcIdx];
      a = regs[ins[25:21]];
      b = regs[ins[20:16]];
      sImm = {{16{ins[15]}}, ins[15:0]};
      zImm = {16'h0000, ins[15:0]};
      addr = a + sImm;
      case (ins[31:26])
        `OP_RTYPE: begin
          case (ins[5:0])
            `FN_ADDU: regs[ins[15:11]] = a + b;
            `FN_SUBU: regs[ins[15:11]] = a - b;
            `FN_AND:  regs[ins[15:11]] = a & b;
            `FN_OR:   regs[ins[15:11]] = a | b;
            `FN_SLT:  regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        `OP_ADDIU: regs[ins[20:16]] = a + sImm;
        `OP_ORI:   regs[ins[20:16]] = a | zImm;
        `OP_LUI:   regs[ins[20:16]] = {ins[15:0], 16'h0000};
        `OP_LW:    regs[ins[20:16]] = refMem[addr[7:2]];
        `OP_SW: begin
          refMem[addr[7:2]] = b;
          chk0.addExpected(addr, b);
        end
        `OP_BEQ: if (a == b) pcIdx = pcIdx + int'($signed(ins[15:0]));
        `OP_BNE: if (a != b) pcIdx = pcIdx + int'($signed(ins[15:0]));
        `OP_HALT: done = 1'b1;
        default: ;
      endcase
      regs[0] = '0;
      pcIdx++;
      steps++;
    end
  endtask

  //////////////////////////////
  // Test sequencing
  //////////////////////////////

  task automatic runTest(input string name, input int kinds, input logic waits);
    @(posedge CLK);
    nRST <= 1'b0;
    waitMode <= waits;
    chk0.startTest(name);
    buildProgram(kinds);
    for (int i = 0; i < 64; i++) begin
      dmem[i] = $urandom;
    end
    runModel();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    chk0.checkReset();
    @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    while (!halt) @(negedge CLK);
    // Quiet window after halt
    repeat (20) @(negedge CLK);
    @(posedge CLK);
    chk0.finishTest();
  endtask

  initial begin
    nRST = 1'b0;
    ihit = 1'b0;
    dhit = 1'b0;
    waitMode = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
      dmem[i] = '0;
    end
    seedVal = 32'hfd846c75;
    dummy = $urandom(seedVal);
    runTest("aluOnly", kindAlu, 1'b0);
    runTest("immediate", kindImm, 1'b0);
    runTest("loadStore", kindAlu | kindMem, 1'b0);
    runTest("branch", kindAlu | kindImm | kindBr, 1'b0);
    runTest("mixedWaits", kindAlu | kindImm | kindMem | kindBr, 1'b1);
    runTest("mixedWaitsAgain", kindAlu | kindImm | kindMem | kindBr, 1'b1);
    chk0.reportTotals();
    if (chk0.testsFailed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
  parameter int periodNs = 20
) (
  output logic CLK
);

  // Starts low, first rising edge at half a period
  initial begin
    CLK = 1'b0;
    forever #(periodNs / 2) CLK = ~CLK;
  end

endmodule

// ==== verilog.f ====
+incdir+include
src/cpuTypesPkg.sv
src/pipeRegister.sv
src/registerFile.sv
src/controlUnit.sv
src/alu.sv
src/hazardUnit.sv
src/datapath.sv
test/tbClock.sv
test/cpuChecker.sv
test/cpuTb.sv
